// File: build.f
rtl/isa_pkg.sv
rtl/branch_pkg.sv
rtl/branch_decode.sv
rtl/branch_queue.sv
rtl/branch_unit.sv
rtl/branch_subsystem.sv
bench/branch_subsystem_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
    --top-module branch_subsystem_tb -o branch_sim

./obj_dir/branch_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"

// File: bench/branch_stimulus.txt
// inst pc rs1 rs2 predict | expected: taken target mispredict link_reg
// rows 0-11 conditional branches, 12 JAL, 13 JALR, 14 ADDI (not a branch)
00208863 00001000 FFFFFFF0 FFFFFFF0 1 1 00001010 0 00
FE208CE3 00001004 FFFFFFF0 00000010 1 0 00000FFC 1 00
00209863 00001008 FFFFFFFF 00000001 0 1 00001018 1 00
FE209CE3 0000100C 80000000 80000000 0 0 00001004 0 00
0020C863 00001010 FFFFFFFE 00000003 1 1 00001020 0 00
FE20CCE3 00001014 00000005 FFFFFFFB 1 0 0000100C 1 00
0020D863 00001018 FFFFFFFF 80000000 0 1 00001028 1 00
FE20DCE3 0000101C FFFFFFF0 FFFFFFFF 0 0 00001014 0 00
0020E863 00001020 00000005 FFFFFFFB 1 1 00001030 0 00
FE20ECE3 00001024 FFFFFFFE 00000003 0 0 0000101C 0 00
0020F863 00001028 80000000 7FFFFFFF 0 1 00001038 1 00
FE20FCE3 0000102C 00000001 FFFFFFFF 1 0 00001024 1 00
100000EF 00002000 00000000 00000000 0 1 00002100 1 01
FFC302E7 00003000 00004008 00000000 1 1 00004004 0 05
00108193 00004000 00000001 00000000 0 0 00000000 0 00

// File: bench/branch_subsystem_tb.sv
`timescale 1ns/1ns

module branch_subsystem_tb;

    localparam int ROWS        = 15;
    localparam int COLS        = 9;
    localparam int ADDI_ROW    = 14;
    localparam int CYCLE_LIMIT = 40 * ROWS + 200;

    logic        clock = 1'b0;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic        predict_taken;
    logic        resolve;
    logic        result_valid;
    logic [31:0] target_pc;
    logic        actual_taken;
    logic        mispredict;
    logic [31:0] link_value;
    logic [4:0]  link_reg;
    logic        queue_full;
    logic        queue_overflow;
    logic [2:0]  queue_count;

    logic [31:0] stim [ROWS * COLS];
    int          seed = 24914;
    int          cycles = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          errors_before = 0;

    branch_subsystem #(.DEPTH(4)) UUT (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors == errors_before) begin
            $display("[PASS] %s", name);
        end else begin
            failed_tests++;
            $display("[FAIL] %s", name);
        end
        errors_before = errors;
    endtask

    // Starts and ends on a falling edge
    task automatic push_row(int row);
        int b;
        b             = row * COLS;
        inst_valid    = 1'b1;
        inst          = stim[b];
        pc            = stim[b + 1];
        rs1_value     = stim[b + 2];
        rs2_value     = stim[b + 3];
        predict_taken = stim[b + 4][0];
        @(negedge clock);
        inst_valid    = 1'b0;
    endtask

    task automatic resolve_row(int row, bit want_result);
        int b;
        int gap;
        b   = row * COLS;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge clock);
        resolve = 1'b1;
        @(negedge clock);
        resolve = 1'b0;
        if (result_valid !== 1'b0) report_mismatch("result_valid", 32'd0, 32'(result_valid));
        @(negedge clock); // Result registered one edge after the pop
        if (!want_result) begin
            if (result_valid !== 1'b0) report_mismatch("result_valid", 32'd0, 32'(result_valid));
        end else begin
            if (result_valid !== 1'b1) report_mismatch("result_valid", 32'd1, 32'(result_valid));
            if (actual_taken !== stim[b + 5][0])
                report_mismatch("actual_taken", 32'(stim[b + 5][0]), 32'(actual_taken));
            if (target_pc !== stim[b + 6]) report_mismatch("target_pc", stim[b + 6], target_pc);
            if (mispredict !== stim[b + 7][0])
                report_mismatch("mispredict", 32'(stim[b + 7][0]), 32'(mispredict));
            if (link_value !== stim[b + 1] + 32'd4)
                report_mismatch("link_value", stim[b + 1] + 32'd4, link_value);
            if (link_reg !== stim[b + 8][4:0])
                report_mismatch("link_reg", 32'(stim[b + 8][4:0]), 32'(link_reg));
        end
    endtask

    initial begin
        reset         = 1'b1;
        inst_valid    = 1'b0;
        inst          = '0;
        pc            = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        predict_taken = 1'b0;
        resolve       = 1'b0;
        $readmemh("bench/branch_stimulus.txt", stim);
        repeat (16) @(negedge clock);
        reset = 1'b0;

        for (int r = 0; r < ADDI_ROW; r++) begin
            push_row(r);
            @(negedge clock);
            resolve_row(r, 1'b1);
            end_test($sformatf("branch row %0d", r));
        end

        push_row(ADDI_ROW);
        @(negedge clock);
        if (queue_count !== 3'd0) report_mismatch("queue_count", 32'd0, 32'(queue_count));
        resolve_row(ADDI_ROW, 1'b0);
        end_test("non-branch filtered");

        push_row(2);
        push_row(5);
        push_row(8);
        @(negedge clock);
        if (queue_count !== 3'd3) report_mismatch("queue_count", 32'd3, 32'(queue_count));
        resolve_row(2, 1'b1);
        resolve_row(5, 1'b1);
        resolve_row(8, 1'b1);
        end_test("order and latency");

        for (int r = 0; r < 5; r++) begin
            push_row(r);
        end
        if (queue_count !== 3'd4) report_mismatch("queue_count", 32'd4, 32'(queue_count));
        if (queue_full !== 1'b1) report_mismatch("queue_full", 32'd1, 32'(queue_full));
        @(negedge clock); // Fifth push dropped here
        if (queue_overflow !== 1'b1) report_mismatch("queue_overflow", 32'd1, 32'(queue_overflow));
        for (int r = 0; r < 4; r++) begin
            resolve_row(r, 1'b1);
        end
        resolve_row(4, 1'b0);
        end_test("overflow");

        push_row(0);
        push_row(1);
        @(negedge clock);
        resolve = 1'b1;
        @(negedge clock);
        resolve = 1'b0;
        if (queue_overflow !== 1'b1) report_mismatch("queue_overflow", 32'd1, 32'(queue_overflow));
        reset = 1'b1; // Row 0 result due at this edge
        @(negedge clock);
        reset = 1'b0;
        if (result_valid !== 1'b0) report_mismatch("result_valid", 32'd0, 32'(result_valid));
        if (queue_count !== 3'd0) report_mismatch("queue_count", 32'd0, 32'(queue_count));
        if (queue_overflow !== 1'b0) report_mismatch("queue_overflow", 32'd0, 32'(queue_overflow));
        push_row(3);
        @(negedge clock);
        resolve_row(3, 1'b1);
        end_test("reset in mid-run");

        $display("Summary: %0d tests, %0d failed, %0d check errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: rtl/branch_subsystem.sv
`timescale 1ns/1ns

module branch_subsystem #(
    parameter int DEPTH = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  logic [31:0]            inst,
    input  logic [31:0]            pc,
    input  logic [31:0]            rs1_value,
    input  logic [31:0]            rs2_value,
    input  logic                   predict_taken,
    input  logic                   resolve,
    output logic                   result_valid,
    output logic [31:0]            target_pc,
    output logic                   actual_taken,
    output logic                   mispredict,
    output logic [31:0]            link_value,
    output logic [4:0]             link_reg,
    output logic                   queue_full,
    output logic                   queue_overflow,
    output logic [$clog2(DEPTH):0] queue_count
);

    logic                       decode_valid;
    branch_pkg::branch_packet_t decode_packet;
    logic                       issue_valid;
    branch_pkg::branch_packet_t issue_packet;
    branch_pkg::branch_result_t result;

    branch_decode u_decode (
        .clock         (clock),
        .reset         (reset),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .pc            (pc),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .predict_taken (predict_taken),
        .decode_valid  (decode_valid),
        .decode_packet (decode_packet)
    );

    branch_queue #(
        .DEPTH (DEPTH)
    ) u_queue (
        .clock         (clock),
        .reset         (reset),
        .decode_valid  (decode_valid),
        .decode_packet (decode_packet),
        .resolve       (resolve),
        .issue_valid   (issue_valid),
        .issue_packet  (issue_packet),
        .full          (queue_full),
        .overflow      (queue_overflow),
        .count         (queue_count)
    );

    branch_unit u_unit (
        .clock        (clock),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_packet (issue_packet),
        .result_valid (result_valid),
        .result       (result)
    );

    assign target_pc    = result.target_pc;
    assign actual_taken = result.actual_taken;
    assign mispredict   = result.mispredict;
    assign link_value   = result.link_value;
    assign link_reg     = result.link_reg;

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       issue_valid,
    input  branch_pkg::branch_packet_t issue_packet,
    output logic                       result_valid,
    output branch_pkg::branch_result_t result
);

    branch_pkg::data_t opa;
    branch_pkg::data_t opb;
    branch_pkg::data_t rs1;
    branch_pkg::data_t rs2;
    logic              take;

    assign rs1 = issue_packet.source_reg_1;
    assign rs2 = issue_packet.source_reg_2;

    always_comb begin
        case (issue_packet.opa_select)
            branch_pkg::OPA_IS_RS1: opa = rs1;
            branch_pkg::OPA_IS_PC:  opa = issue_packet.pc;
            default:                opa = '0;
        endcase
    end

    always_comb begin
        case (issue_packet.opb_select)
            branch_pkg::OPB_IS_B_IMM: opb = isa_pkg::signext_b_imm(issue_packet.inst);
            branch_pkg::OPB_IS_I_IMM: opb = isa_pkg::signext_i_imm(issue_packet.inst);
            branch_pkg::OPB_IS_J_IMM: opb = isa_pkg::signext_j_imm(issue_packet.inst);
            default:                  opb = '0;
        endcase
    end

    always_comb begin
        if (issue_packet.conditional) begin
            case (issue_packet.branch_func)
                3'b000:  take = (rs1 == rs2);                   // BEQ
                3'b001:  take = (rs1 != rs2);                   // BNE
                3'b100:  take = ($signed(rs1) < $signed(rs2));  // BLT
                3'b101:  take = ($signed(rs1) >= $signed(rs2)); // BGE
                3'b110:  take = (rs1 < rs2);                    // BLTU
                3'b111:  take = (rs1 >= rs2);                   // BGEU
                default: take = 1'b0;
            endcase
        end else begin
            take = 1'b1; // JAL and JALR
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result.target_pc    <= opa + opb;
            result.actual_taken <= take;
            result.mispredict   <= (issue_packet.predict_taken != take);
            result.link_value   <= issue_packet.npc;
            result.link_reg     <= issue_packet.dest_reg_idx;
        end
    end

    // Selects come from the decoder through the queue storage
    assert property (@(posedge clock) disable iff (reset)
        issue_valid |->
            (issue_packet.opa_select inside {branch_pkg::OPA_IS_RS1, branch_pkg::OPA_IS_PC}) &&
            (issue_packet.opb_select inside {branch_pkg::OPB_IS_B_IMM,
                                             branch_pkg::OPB_IS_I_IMM,
                                             branch_pkg::OPB_IS_J_IMM}));

endmodule

// File: rtl/branch_queue.sv
`timescale 1ns/1ns

module branch_queue #(
    parameter int DEPTH = 4
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       decode_valid,
    input  branch_pkg::branch_packet_t decode_packet,
    input  logic                       resolve,
    output logic                       issue_valid,
    output branch_pkg::branch_packet_t issue_packet,
    output logic                       full,
    output logic                       overflow,
    output logic [$clog2(DEPTH):0]     count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH) + 1;

    branch_pkg::branch_packet_t entries [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic                       pop_request;
    logic                       do_push;
    logic                       do_pop;

    if (DEPTH < 2) begin : g_depth_check
        $error("branch_queue needs DEPTH of at least 2");
    end

    assign full         = (count == CNT_W'(DEPTH));
    assign do_push      = decode_valid && !full;
    assign do_pop       = pop_request;
    assign issue_valid  = pop_request;
    assign issue_packet = entries[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= decode_packet;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            pop_request <= 1'b0;
            overflow    <= 1'b0;
        end else begin
            // Entry already being issued is not available again
            pop_request <= resolve && (count > CNT_W'(issue_valid));
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (decode_valid && full) begin
                overflow <= 1'b1; // Sticky until reset
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        count <= CNT_W'(DEPTH));

    assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> count != '0);

endmodule

// File: rtl/branch_decode.sv
`timescale 1ns/1ns

module branch_decode (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       inst_valid,
    input  isa_pkg::inst_t             inst,
    input  branch_pkg::data_t          pc,
    input  branch_pkg::data_t          rs1_value,
    input  branch_pkg::data_t          rs2_value,
    input  logic                       predict_taken,
    output logic                       decode_valid,
    output branch_pkg::branch_packet_t decode_packet
);

    isa_pkg::opcode_t           opcode;
    logic                       is_branch;
    branch_pkg::branch_packet_t next_packet;

    assign opcode = isa_pkg::opcode_t'(inst.i.opcode);

    always_comb begin
        next_packet               = '0;
        is_branch                 = 1'b0;
        next_packet.inst          = inst;
        next_packet.pc            = pc;
        next_packet.npc           = pc + 32'd4;
        next_packet.source_reg_1  = rs1_value;
        next_packet.source_reg_2  = rs2_value;
        next_packet.branch_func   = inst.b.funct3;
        next_packet.predict_taken = predict_taken;
        next_packet.dest_reg_idx  = inst.i.rd;
        case (opcode)
            isa_pkg::OP_BRANCH: begin
                is_branch                = 1'b1;
                next_packet.conditional  = 1'b1;
                next_packet.opa_select   = branch_pkg::OPA_IS_PC;
                next_packet.opb_select   = branch_pkg::OPB_IS_B_IMM;
                next_packet.dest_reg_idx = '0; // No link write
            end
            isa_pkg::OP_JAL: begin
                is_branch               = 1'b1;
                next_packet.opa_select  = branch_pkg::OPA_IS_PC;
                next_packet.opb_select  = branch_pkg::OPB_IS_J_IMM;
            end
            isa_pkg::OP_JALR: begin
                is_branch               = 1'b1;
                next_packet.opa_select  = branch_pkg::OPA_IS_RS1;
                next_packet.opb_select  = branch_pkg::OPB_IS_I_IMM;
            end
            default: is_branch = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            decode_valid <= 1'b0;
        end else begin
            decode_valid <= inst_valid && is_branch;
        end
    end

    always_ff @(posedge clock) begin
        if (inst_valid) begin
            decode_packet <= next_packet;
        end
    end

    // A packet only follows an instruction strobe one edge earlier
    assert property (@(posedge clock) disable iff (reset)
        decode_valid |-> $past(inst_valid));

endmodule

// File: rtl/branch_pkg.sv
package branch_pkg;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [1:0] {
        OPA_IS_RS1 = 2'd0,
        OPA_IS_PC  = 2'd1
    } opa_select_t;

    typedef enum logic [1:0] {
        OPB_IS_B_IMM = 2'd0,
        OPB_IS_I_IMM = 2'd1,
        OPB_IS_J_IMM = 2'd2
    } opb_select_t;

    typedef struct packed {
        isa_pkg::inst_t inst;
        data_t          pc;
        data_t          npc;           // pc + 4, also the link value
        data_t          source_reg_1;
        data_t          source_reg_2;
        opa_select_t    opa_select;
        opb_select_t    opb_select;
        logic           conditional;
        logic [2:0]     branch_func;   // funct3 of a conditional branch
        logic           predict_taken;
        reg_idx_t       dest_reg_idx;
    } branch_packet_t;

    typedef struct packed {
        data_t    target_pc;
        logic     actual_taken;
        logic     mispredict;
        data_t    link_value;
        reg_idx_t link_reg;
    } branch_result_t;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One word seen through each format
    typedef union packed {
        b_type_t b;
        i_type_t i;
        j_type_t j;
    } inst_t;

    function automatic logic [31:0] signext_i_imm(inst_t inst);
        return {{20{inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic logic [31:0] signext_b_imm(inst_t inst);
        return {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    endfunction

    function automatic logic [31:0] signext_j_imm(inst_t inst);
        return {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                inst.j.imm_11, inst.j.imm_10_1, 1'b0};
    endfunction

endpackage
